//--- vslide_unit.f
verilog/vslide_pkg.sv
verilog/vslide_decode.sv
verilog/vslide_execute.sv
verilog/vslide_result.sv
verilog/vslide_unit.sv
test/vslide_checker.sv
test/vslide_unit_tb.sv

//--- Bender.yml
package:
  name: vslide_unit

sources:
  - files:
      - verilog/vslide_pkg.sv
      - verilog/vslide_decode.sv
      - verilog/vslide_execute.sv
      - verilog/vslide_result.sv
      - verilog/vslide_unit.sv
  - target: test
    files:
      - test/vslide_checker.sv
      - test/vslide_unit_tb.sv

//--- test/vslide_unit_tb.sv
// testbench top for the vector slide unit
// stimulus table, clock, reset, register file back-pressure and timeout
`timescale 1ns/1ps
`default_nettype none

module vslide_unit_tb;

    import vslide_pkg::*;

    localparam int CASE_CNT    = 12;
    localparam int CYCLE_LIMIT = CASE_CNT * 40 + 20;

    logic                clk;
    logic                rst;
    logic                instr_valid;
    logic                instr_ready;
    sld_instr_t          instr;
    logic                wr_valid;
    logic                wr_ready;
    logic [VADDR_W-1:0]  wr_addr;
    logic [VREG_B-1:0]   wr_be;
    logic [VREG_W-1:0]   wr_data;
    logic                done_valid;
    logic [XIF_ID_W-1:0] done_id;
    int                  done_cnt;
    int                  fail_cnt;
    int                  err_cnt;

    sld_instr_t          case_tab [CASE_CNT];
    string               name_tab [CASE_CNT];
    int                  case_num;
    int unsigned         seed;

    vslide_unit dut_i (
        .clk_i              ( clk         ),
        .rst_i              ( rst         ),
        .instr_valid_i      ( instr_valid ),
        .instr_ready_o      ( instr_ready ),
        .instr_i            ( instr       ),
        .vreg_wr_valid_o    ( wr_valid    ),
        .vreg_wr_ready_i    ( wr_ready    ),
        .vreg_wr_addr_o     ( wr_addr     ),
        .vreg_wr_be_o       ( wr_be       ),
        .vreg_wr_data_o     ( wr_data     ),
        .instr_done_valid_o ( done_valid  ),
        .instr_done_id_o    ( done_id     )
    );

    vslide_checker check_i (
        .clk_i              ( clk         ),
        .rst_i              ( rst         ),
        .vreg_wr_valid_i    ( wr_valid    ),
        .vreg_wr_ready_i    ( wr_ready    ),
        .vreg_wr_addr_i     ( wr_addr     ),
        .vreg_wr_be_i       ( wr_be       ),
        .vreg_wr_data_i     ( wr_data     ),
        .instr_done_valid_i ( done_valid  ),
        .instr_done_id_i    ( done_id     ),
        .done_cnt_o         ( done_cnt    ),
        .fail_cnt_o         ( fail_cnt    ),
        .err_cnt_o          ( err_cnt     )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus table

    task automatic add_case(input string name, input sld_op_e op, input cfg_vsew_e vsew,
                            input logic [XIF_ID_W-1:0] id, input logic [VL_W-1:0] vl,
                            input logic [31:0] xval, input logic [VADDR_W-1:0] vd);
        sld_instr_t in;
        in.id   = id;
        in.op   = op;
        in.vsew = vsew;
        in.vl   = vl;
        in.xval = xval;
        in.vd   = vd;
        for (int k = 0; k < 4; k++) begin
            in.vs2[32*k +: 32] = $urandom;
        end
        case_tab[case_num] = in;
        name_tab[case_num] = name;
        case_num++;
    endtask

    // holds valid until the DUT takes the instruction
    task automatic send_instr(input int t);
        instr_valid = 1'b1;
        instr       = case_tab[t];
        @(negedge clk);
        while (!instr_ready) @(negedge clk);
        check_i.push_expected(name_tab[t], case_tab[t]);   // accepted on the next edge
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed = 32'hab53c96e;
        void'($urandom(seed));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        case_num    = 0;

        add_case("up_e8_off3",    SLD_VSLIDEUP,    VSEW_8,  3'd0, 5'd16, 32'd3,        5'd1);
        add_case("up_e16_off2",   SLD_VSLIDEUP,    VSEW_16, 3'd1, 5'd6,  32'd2,        5'd2);
        add_case("up_e32_off1",   SLD_VSLIDEUP,    VSEW_32, 3'd2, 5'd4,  32'd1,        5'd3);
        add_case("down_e8_off5",  SLD_VSLIDEDOWN,  VSEW_8,  3'd3, 5'd16, 32'd5,        5'd4);
        add_case("down_e16_sat",  SLD_VSLIDEDOWN,  VSEW_16, 3'd4, 5'd7,  32'd9,        5'd5);
        add_case("down_big_off",  SLD_VSLIDEDOWN,  VSEW_32, 3'd5, 5'd3,  32'h8000_0000, 5'd6);
        add_case("s1up_e16",      SLD_VSLIDE1UP,   VSEW_16, 3'd6, 5'd8,  32'hbeef_cafe, 5'd7);
        add_case("s1down_e32",    SLD_VSLIDE1DOWN, VSEW_32, 3'd7, 5'd3,  32'h1234_5678, 5'd8);
        add_case("s1down_e8",     SLD_VSLIDE1DOWN, VSEW_8,  3'd0, 5'd11, 32'h0000_00a5, 5'd9);
        add_case("vl_zero",       SLD_VSLIDEDOWN,  VSEW_8,  3'd1, 5'd0,  32'd1,        5'd10);
        add_case("up_past_vl",    SLD_VSLIDEUP,    VSEW_16, 3'd2, 5'd4,  32'd5,        5'd11);
        add_case("s1up_e8_vl1",   SLD_VSLIDE1UP,   VSEW_8,  3'd3, 5'd1,  32'h0000_0077, 5'd12);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 0; t < CASE_CNT; t++) begin
            send_instr(t);   // back to back
        end
        instr_valid = 1'b0;

        while (done_cnt < CASE_CNT) @(posedge clk);
        repeat (10) @(posedge clk);   // room for a stray write or done
        $display("tests %0d  passed %0d  failed %0d  errors %0d",
                 CASE_CNT, done_cnt - fail_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // register file ready, low about one cycle in four
    initial begin
        wr_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            wr_ready = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions completed",
                 cycles, done_cnt, CASE_CNT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/vslide_checker.sv
// testbench checker for the vector slide unit
// slide reference model, register write and done monitoring
`timescale 1ns/1ps
`default_nettype none

module vslide_checker (
    input  wire logic                            clk_i,
    input  wire logic                            rst_i,
    input  wire logic                            vreg_wr_valid_i,
    input  wire logic                            vreg_wr_ready_i,
    input  wire logic [vslide_pkg::VADDR_W-1:0]  vreg_wr_addr_i,
    input  wire logic [vslide_pkg::VREG_B-1:0]   vreg_wr_be_i,
    input  wire logic [vslide_pkg::VREG_W-1:0]   vreg_wr_data_i,
    input  wire logic                            instr_done_valid_i,
    input  wire logic [vslide_pkg::XIF_ID_W-1:0] instr_done_id_i,
    output int                                   done_cnt_o,
    output int                                   fail_cnt_o,
    output int                                   err_cnt_o
);

    import vslide_pkg::*;

    localparam int DEPTH     = 64;
    localparam int REG_BYTES = VREG_B;

    string               exp_name [DEPTH];
    logic [VADDR_W-1:0]  exp_addr [DEPTH];
    logic [VREG_B-1:0]   exp_be   [DEPTH];
    logic [VREG_W-1:0]   exp_data [DEPTH];
    logic [XIF_ID_W-1:0] exp_id   [DEPTH];
    int                  push_cnt;
    int                  pop_cnt;
    int                  test_err;
    logic                write_seen;
    logic                held;        // write waiting on ready
    logic [VADDR_W-1:0]  held_addr;
    logic [VREG_B-1:0]   held_be;
    logic [VREG_W-1:0]   held_data;

    initial begin
        push_cnt   = 0;
        pop_cnt    = 0;
        test_err   = 0;
        write_seen = 1'b0;
        held       = 1'b0;
        done_cnt_o = 0;
        fail_cnt_o = 0;
        err_cnt_o  = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [7:0] byte_at(input logic [VREG_W-1:0] v, input int idx);
        logic [VREG_W-1:0] s;
        s = v >> (8 * idx);
        return s[7:0];
    endfunction

    task automatic slide_model(input sld_instr_t in, output logic [VREG_B-1:0] be,
                               output logic [VREG_W-1:0] data);
        int         e;
        int         l;
        int         b;
        logic       en;
        logic [7:0] val;

        case (in.vsew)
            VSEW_16: e = 2;
            VSEW_32: e = 4;
            default: e = 1;
        endcase
        l = int'(in.vl) * e;
        if (l > REG_BYTES) l = REG_BYTES;
        if (in.op == SLD_VSLIDE1UP || in.op == SLD_VSLIDE1DOWN) begin
            b = e;
        end else if (in.xval >= 32'(REG_BYTES)) begin
            b = REG_BYTES;
        end else begin
            b = int'(in.xval) * e;
            if (b > REG_BYTES) b = REG_BYTES;
        end

        be   = '0;
        data = '0;
        for (int i = 0; i < REG_BYTES; i++) begin
            en  = (i < l);
            val = (i + b < REG_BYTES) ? byte_at(in.vs2, i + b) : 8'h00;   // slidedown source
            case (in.op)
                SLD_VSLIDEUP: begin
                    en  = (i >= b) && (i < l);
                    val = byte_at(in.vs2, i - b);
                end
                SLD_VSLIDE1UP: begin
                    val = (i < e) ? byte_at(in.xval, i) : byte_at(in.vs2, i - e);
                end
                SLD_VSLIDE1DOWN: begin
                    if (i >= l - e) val = byte_at(in.xval, i - (l - e));
                end
                default: ;
            endcase
            if (en) begin
                be[i]          = 1'b1;
                data[8*i +: 8] = val;
            end
        end
    endtask

    // called by the testbench when an instruction is accepted
    task automatic push_expected(input string name, input sld_instr_t instr);
        int                slot;
        logic [VREG_B-1:0] be;
        logic [VREG_W-1:0] data;
        slot = push_cnt % DEPTH;
        slide_model(instr, be, data);
        exp_name[slot] = name;
        exp_addr[slot] = instr.vd;
        exp_id[slot]   = instr.id;
        exp_be[slot]   = be;
        exp_data[slot] = data;
        push_cnt++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparing

    task automatic report_value(input string what, input logic [VREG_W-1:0] exp_v,
                                input logic [VREG_W-1:0] act_v);
        $display("[FAIL] %s: %s expected %0h actual %0h",
                 exp_name[pop_cnt % DEPTH], what, exp_v, act_v);
        test_err++;
        err_cnt_o++;
    endtask

    task automatic match_write();
        int slot;
        slot = pop_cnt % DEPTH;
        if (pop_cnt == push_cnt) begin
            $display("register write arrived with no instruction outstanding");
            err_cnt_o++;
        end else if (exp_be[slot] == '0) begin
            $display("register write arrived for %s, which enables no byte", exp_name[slot]);
            test_err++;
            err_cnt_o++;
        end else if (write_seen) begin
            $display("second register write arrived for %s", exp_name[slot]);
            test_err++;
            err_cnt_o++;
        end else begin
            write_seen = 1'b1;
            if (vreg_wr_addr_i !== exp_addr[slot])
                report_value("address", exp_addr[slot], vreg_wr_addr_i);
            if (vreg_wr_be_i !== exp_be[slot])
                report_value("byte enables", exp_be[slot], vreg_wr_be_i);
            if (vreg_wr_data_i !== exp_data[slot])
                report_value("data", exp_data[slot], vreg_wr_data_i);
        end
    endtask

    task automatic close_test();
        int slot;
        slot = pop_cnt % DEPTH;
        if (pop_cnt == push_cnt) begin
            $display("done pulse arrived with no instruction outstanding");
            err_cnt_o++;
        end else begin
            if (exp_be[slot] != '0 && !write_seen) begin
                $display("%s completed without its register write", exp_name[slot]);
                test_err++;
                err_cnt_o++;
            end
            if (instr_done_id_i !== exp_id[slot])
                report_value("done id", exp_id[slot], instr_done_id_i);
            if (test_err == 0) begin
                $display("[PASS] %s", exp_name[slot]);
            end else begin
                $display("test %s failed with %0d errors", exp_name[slot], test_err);
                fail_cnt_o++;
            end
            done_cnt_o++;
            pop_cnt++;
            test_err   = 0;
            write_seen = 1'b0;
        end
    endtask

    // write hold, write handshake and done monitor
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (held) begin
                if (vreg_wr_valid_i !== 1'b1) begin
                    $display("write valid dropped before the register file took it");
                    test_err++;
                    err_cnt_o++;
                end else if (vreg_wr_addr_i !== held_addr || vreg_wr_be_i !== held_be ||
                             vreg_wr_data_i !== held_data) begin
                    $display("write payload changed while waiting for ready");
                    test_err++;
                    err_cnt_o++;
                end
            end
            held      = (vreg_wr_valid_i === 1'b1) && (vreg_wr_ready_i !== 1'b1);
            held_addr = vreg_wr_addr_i;
            held_be   = vreg_wr_be_i;
            held_data = vreg_wr_data_i;

            if (vreg_wr_valid_i === 1'b1 && vreg_wr_ready_i === 1'b1) match_write();
            if (instr_done_valid_i === 1'b1) close_test();
        end
    end

endmodule

`default_nettype wire

//--- verilog/vslide_unit.sv
// vector slide unit top level
// decode, execute and result stages in a row
`timescale 1ns/1ps
`default_nettype none

module vslide_unit (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,

    input  wire logic                                instr_valid_i,
    output logic                                     instr_ready_o,
    input  wire vslide_pkg::sld_instr_t              instr_i,

    output logic                                     vreg_wr_valid_o,
    input  wire logic                                vreg_wr_ready_i,
    output logic [vslide_pkg::VADDR_W-1:0]           vreg_wr_addr_o,
    output logic [vslide_pkg::VREG_B-1:0]            vreg_wr_be_o,
    output logic [vslide_pkg::VREG_W-1:0]            vreg_wr_data_o,

    output logic                                     instr_done_valid_o,
    output logic [vslide_pkg::XIF_ID_W-1:0]          instr_done_id_o
);

    import vslide_pkg::*;

    logic       state_valid;
    sld_state_t state;
    logic       state_take;
    logic       chunk_valid;
    sld_chunk_t chunk;
    logic       chunk_ready;

    vslide_decode decode_i (
        .clk_i         ( clk_i         ),
        .rst_i         ( rst_i         ),
        .instr_valid_i ( instr_valid_i ),
        .instr_ready_o ( instr_ready_o ),
        .instr_i       ( instr_i       ),
        .state_valid_o ( state_valid   ),
        .state_o       ( state         ),
        .state_take_i  ( state_take    )
    );

    vslide_execute execute_i (
        .clk_i         ( clk_i         ),
        .rst_i         ( rst_i         ),
        .state_valid_i ( state_valid   ),
        .state_i       ( state         ),
        .state_take_o  ( state_take    ),
        .chunk_valid_o ( chunk_valid   ),
        .chunk_o       ( chunk         ),
        .chunk_ready_i ( chunk_ready   )
    );

    vslide_result result_i (
        .clk_i              ( clk_i              ),
        .rst_i              ( rst_i              ),
        .chunk_valid_i      ( chunk_valid        ),
        .chunk_i            ( chunk              ),
        .chunk_ready_o      ( chunk_ready        ),
        .vreg_wr_valid_o    ( vreg_wr_valid_o    ),
        .vreg_wr_ready_i    ( vreg_wr_ready_i    ),
        .vreg_wr_addr_o     ( vreg_wr_addr_o     ),
        .vreg_wr_be_o       ( vreg_wr_be_o       ),
        .vreg_wr_data_o     ( vreg_wr_data_o     ),
        .instr_done_valid_o ( instr_done_valid_o ),
        .instr_done_id_o    ( instr_done_id_o    )
    );

endmodule

`default_nettype wire

//--- verilog/vslide_result.sv
// slide result stage
// collects chunks into one register write and reports completion
`timescale 1ns/1ps
`default_nettype none

module vslide_result (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,

    input  wire logic                                chunk_valid_i,
    input  wire vslide_pkg::sld_chunk_t              chunk_i,
    output logic                                     chunk_ready_o,

    output logic                                     vreg_wr_valid_o,
    input  wire logic                                vreg_wr_ready_i,
    output logic [vslide_pkg::VADDR_W-1:0]           vreg_wr_addr_o,
    output logic [vslide_pkg::VREG_B-1:0]            vreg_wr_be_o,
    output logic [vslide_pkg::VREG_W-1:0]            vreg_wr_data_o,

    output logic                                     instr_done_valid_o,
    output logic [vslide_pkg::XIF_ID_W-1:0]          instr_done_id_o
);

    import vslide_pkg::*;

    typedef enum logic {
        RES_COLLECT,
        RES_WRITE
    } res_state_e;

    res_state_e          res_state_q;
    logic                done_q;
    logic [VREG_W-1:0]   buf_data_q;
    logic [VREG_B-1:0]   buf_be_q;
    logic [VADDR_W-1:0]  addr_q;
    logic [XIF_ID_W-1:0] id_q;

    logic                chunk_fire;
    logic                last_fire;
    logic [VREG_B-1:0]   be_merged;

    assign chunk_ready_o = (res_state_q != RES_WRITE);
    assign chunk_fire    = chunk_valid_i & chunk_ready_o;
    assign last_fire     = chunk_fire & (chunk_i.idx == CHUNK_IDX_W'(CHUNK_CNT - 1));

    always_comb begin
        be_merged                              = buf_be_q;
        be_merged[chunk_i.idx*OP_B +: OP_B]    = chunk_i.be;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_state_q <= RES_COLLECT;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            unique case (res_state_q)
                RES_COLLECT: begin
                    if (last_fire) begin
                        if (|be_merged) res_state_q <= RES_WRITE;
                        else            done_q      <= 1'b1;     // nothing to write
                    end
                end
                RES_WRITE: begin
                    if (vreg_wr_ready_i) begin
                        res_state_q <= RES_COLLECT;
                        done_q      <= 1'b1;
                    end
                end
                default: res_state_q <= RES_COLLECT;
            endcase
        end
    end

    // buffers only move while collecting, so the write payload holds
    always_ff @(posedge clk_i) begin
        if (chunk_fire) begin
            buf_data_q[chunk_i.idx*OP_W +: OP_W] <= chunk_i.data;
            buf_be_q                             <= be_merged;
            addr_q                               <= chunk_i.vd;
            id_q                                 <= chunk_i.id;
        end
    end

    assign vreg_wr_valid_o    = (res_state_q == RES_WRITE);
    assign vreg_wr_addr_o     = addr_q;
    assign vreg_wr_be_o       = buf_be_q;
    assign vreg_wr_data_o     = buf_data_q;
    assign instr_done_valid_o = done_q;
    assign instr_done_id_o    = id_q;

endmodule

`default_nettype wire

//--- verilog/vslide_execute.sv
// slide execute stage
// steps through the register one chunk per cycle, forming data and byte enables
`timescale 1ns/1ps
`default_nettype none

module vslide_execute (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,

    input  wire logic                    state_valid_i,
    input  wire vslide_pkg::sld_state_t  state_i,
    output logic                         state_take_o,

    output logic                         chunk_valid_o,
    output vslide_pkg::sld_chunk_t       chunk_o,
    input  wire logic                    chunk_ready_i
);

    import vslide_pkg::*;

    typedef enum logic {
        EX_IDLE,
        EX_RUN
    } ex_state_e;

    ex_state_e              ex_state_q;
    logic [CHUNK_IDX_W-1:0] cnt_q;
    sld_state_t             st_q;
    logic                   chunk_valid_q;
    sld_chunk_t             chunk_q;

    logic                   emit;
    logic [OP_W-1:0]        chunk_data;
    logic [OP_B-1:0]        chunk_be;

    assign state_take_o = (ex_state_q == EX_IDLE) & state_valid_i;
    assign emit         = (ex_state_q == EX_RUN) & chunk_ready_i;

    ////////////////////////////////////////////////////////////////////
    // slide rule on the four bytes of the current chunk

    always_comb begin
        int unsigned pos;
        int unsigned e_b;
        int unsigned l_b;
        int unsigned o_b;

        chunk_data = '0;
        chunk_be   = '0;
        e_b        = st_q.elem_bytes;
        l_b        = st_q.vl_bytes;
        o_b        = st_q.off_bytes;
        for (int j = 0; j < OP_B; j++) begin
            pos = cnt_q * OP_B + j;   // byte within the register
            if (st_q.op == SLD_VSLIDEUP) begin
                if (pos >= o_b && pos < l_b) begin
                    chunk_be[j]          = 1'b1;
                    chunk_data[8*j +: 8] = st_q.vs2[8*(pos-o_b) +: 8];
                end
            end else if (pos < l_b) begin
                chunk_be[j] = 1'b1;
                if (st_q.op == SLD_VSLIDE1UP) begin
                    if (pos < e_b) begin
                        chunk_data[8*j +: 8] = st_q.xval[8*pos +: 8];
                    end else begin
                        chunk_data[8*j +: 8] = st_q.vs2[8*(pos-e_b) +: 8];
                    end
                end else if (st_q.op == SLD_VSLIDE1DOWN && pos + e_b >= l_b) begin
                    chunk_data[8*j +: 8] = st_q.xval[8*(pos+e_b-l_b) +: 8]; // last element
                end else if (pos + o_b < VREG_B) begin
                    chunk_data[8*j +: 8] = st_q.vs2[8*(pos+o_b) +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_state_q    <= EX_IDLE;
            cnt_q         <= '0;
            chunk_valid_q <= 1'b0;
        end else begin
            chunk_valid_q <= emit;
            unique case (ex_state_q)
                EX_IDLE: if (state_take_o) ex_state_q <= EX_RUN;
                EX_RUN: begin
                    if (emit) begin
                        cnt_q <= cnt_q + 1'b1;   // wraps back to chunk 0
                        if (cnt_q == CHUNK_IDX_W'(CHUNK_CNT - 1)) begin
                            ex_state_q <= EX_IDLE;
                        end
                    end
                end
                default: ex_state_q <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_take_o) begin
            st_q <= state_i;
        end
        if (emit) begin
            chunk_q <= '{idx: cnt_q, data: chunk_data, be: chunk_be, id: st_q.id, vd: st_q.vd};
        end
    end

    assign chunk_valid_o = chunk_valid_q;
    assign chunk_o       = chunk_q;

endmodule

`default_nettype wire

//--- verilog/vslide_decode.sv
// slide decode stage
// turns an accepted instruction into byte offset and byte length state
`timescale 1ns/1ps
`default_nettype none

module vslide_decode (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,

    input  wire logic                    instr_valid_i,
    output logic                         instr_ready_o,
    input  wire vslide_pkg::sld_instr_t  instr_i,

    output logic                         state_valid_o,
    output vslide_pkg::sld_state_t       state_o,
    input  wire logic                    state_take_i
);

    import vslide_pkg::*;

    logic       state_valid_q;
    sld_state_t state_q;
    sld_state_t state_init;
    logic       accept;

    logic [1:0] sew_shift;     // log2 of element bytes
    logic [6:0] off_wide;
    logic [6:0] vl_wide;

    // free slot, or the held state leaves this cycle
    assign instr_ready_o = ~state_valid_q | state_take_i;
    assign accept        = instr_valid_i & instr_ready_o;

    ////////////////////////////////////////////////////////////////////
    // initial state

    always_comb begin
        state_init      = '0;
        state_init.id   = instr_i.id;
        state_init.op   = instr_i.op;
        state_init.vd   = instr_i.vd;
        state_init.xval = instr_i.xval;
        state_init.vs2  = instr_i.vs2;

        sew_shift             = 2'd0;
        state_init.elem_bytes = 3'd1;
        unique case (instr_i.vsew)
            VSEW_16: begin
                sew_shift             = 2'd1;
                state_init.elem_bytes = 3'd2;
            end
            VSEW_32: begin
                sew_shift             = 2'd2;
                state_init.elem_bytes = 3'd4;
            end
            default: ;
        endcase

        // element offset to bytes, anything past the register saturates
        if (|instr_i.xval[31:5]) begin
            off_wide = 7'(VREG_B);
        end else begin
            off_wide = {2'b00, instr_i.xval[4:0]} << sew_shift;
        end
        if (off_wide > 7'(VREG_B)) begin
            state_init.off_bytes = OFF_W'(VREG_B);
        end else begin
            state_init.off_bytes = off_wide[OFF_W-1:0];
        end

        // slide1 forms move by one element
        if (instr_i.op == SLD_VSLIDE1UP || instr_i.op == SLD_VSLIDE1DOWN) begin
            state_init.off_bytes = OFF_W'(state_init.elem_bytes);
        end

        vl_wide = {2'b00, instr_i.vl} << sew_shift;
        if (vl_wide > 7'(VREG_B)) begin
            state_init.vl_bytes = OFF_W'(VREG_B);
        end else begin
            state_init.vl_bytes = vl_wide[OFF_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // state register

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_valid_q <= 1'b0;
        end else if (accept) begin
            state_valid_q <= 1'b1;
        end else if (state_take_i) begin
            state_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            state_q <= state_init;
        end
    end

    assign state_valid_o = state_valid_q;
    assign state_o       = state_q;

endmodule

`default_nettype wire

//--- verilog/vslide_pkg.sv
// widths, opcode and element width enums
// packed structs for instruction, decoded state and result chunks
`default_nettype none

package vslide_pkg;

    ////////////////////////////////////////////////////////////////////
    // sizes

    localparam int unsigned VREG_W      = 128;           // vector register bits
    localparam int unsigned VREG_B      = VREG_W / 8;
    localparam int unsigned OP_W        = 32;            // execute chunk bits
    localparam int unsigned OP_B        = OP_W / 8;
    localparam int unsigned CHUNK_CNT   = VREG_W / OP_W;
    localparam int unsigned CHUNK_IDX_W = $clog2(CHUNK_CNT);
    localparam int unsigned XIF_ID_W    = 3;
    localparam int unsigned VL_W        = 5;             // 0 to 16 elements
    localparam int unsigned OFF_W       = 5;             // 0 to 16 bytes
    localparam int unsigned VADDR_W     = 5;

    ////////////////////////////////////////////////////////////////////
    // encodings

    typedef enum logic [1:0] {
        SLD_VSLIDEUP    = 2'd0,
        SLD_VSLIDEDOWN  = 2'd1,
        SLD_VSLIDE1UP   = 2'd2,
        SLD_VSLIDE1DOWN = 2'd3
    } sld_op_e;

    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } cfg_vsew_e;

    ////////////////////////////////////////////////////////////////////
    // pipeline payloads

    typedef struct packed {
        logic [XIF_ID_W-1:0] id;
        sld_op_e             op;
        cfg_vsew_e           vsew;
        logic [VL_W-1:0]     vl;
        logic [31:0]         xval;     // element offset or slide1 scalar
        logic [VADDR_W-1:0]  vd;
        logic [VREG_W-1:0]   vs2;
    } sld_instr_t;

    typedef struct packed {
        logic [XIF_ID_W-1:0] id;
        sld_op_e             op;
        logic [VADDR_W-1:0]  vd;
        logic [31:0]         xval;
        logic [2:0]          elem_bytes;
        logic [OFF_W-1:0]    off_bytes;
        logic [OFF_W-1:0]    vl_bytes;
        logic [VREG_W-1:0]   vs2;
    } sld_state_t;

    typedef struct packed {
        logic [CHUNK_IDX_W-1:0] idx;
        logic [OP_W-1:0]        data;
        logic [OP_B-1:0]        be;
        logic [XIF_ID_W-1:0]    id;
        logic [VADDR_W-1:0]     vd;
    } sld_chunk_t;

endpackage

`default_nettype wire
